//--- isaPkg.sv
package isaPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_BLE   = 6'h06;
    localparam opcode_t OP_BGT   = 6'h07;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_RESET = 6'h3f;  // All ones halts the core

    // R-type function codes
    localparam funct_t FN_MFHI = 6'h10;
    localparam funct_t FN_MFLO = 6'h12;
    localparam funct_t FN_MULT = 6'h18;
    localparam funct_t FN_DIV  = 6'h1a;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;

    // One class per supported instruction
    typedef enum logic [3:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsAddi,
        clsMult,
        clsDiv,
        clsMfhi,
        clsMflo,
        clsBne,
        clsBeq,
        clsBle,
        clsBgt,
        clsReset,
        clsUnknown
    } instrClass_t;

endpackage

//--- ctrlPkg.sv
package ctrlPkg;

    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] regDst_t;
    typedef logic [1:0] aluSrcB_t;
    typedef logic [2:0] pcSource_t;
    typedef logic [2:0] memToReg_t;
    typedef logic [1:0] condCtrl_t;

    localparam aluOp_t ALU_ADD = 3'd1;
    localparam aluOp_t ALU_SUB = 3'd2;
    localparam aluOp_t ALU_AND = 3'd3;
    localparam aluOp_t ALU_CMP = 3'd7;

    localparam regDst_t REG_DST_RT = 2'd0;
    localparam regDst_t REG_DST_RD = 2'd1;

    localparam aluSrcB_t SRCB_B         = 2'd0;
    localparam aluSrcB_t SRCB_IMM       = 2'd1;
    localparam aluSrcB_t SRCB_IMM_SHIFT = 2'd2;  // Branch offset
    localparam aluSrcB_t SRCB_FOUR      = 2'd3;

    localparam pcSource_t PC_SRC_ALU    = 3'd0;
    localparam pcSource_t PC_SRC_BRANCH = 3'd3;

    localparam memToReg_t MEM_TO_REG_ALUOUT = 3'd0;
    localparam memToReg_t MEM_TO_REG_HI     = 3'd2;
    localparam memToReg_t MEM_TO_REG_LO     = 3'd3;

    localparam condCtrl_t COND_NE = 2'd0;
    localparam condCtrl_t COND_EQ = 2'd1;
    localparam condCtrl_t COND_LE = 2'd2;
    localparam condCtrl_t COND_GT = 2'd3;

    typedef enum logic [3:0] {
        stReset,
        stFetchWait,
        stFetchLoad,
        stDecode,
        stDispatch,
        stAluCompute,
        stAluWrite,
        stMulDivRun,
        stHiLoWrite,
        stMoveSelect,
        stMoveWrite,
        stBranch,
        stHalt
    } seqState_t;

    // Step plus the class it executes
    typedef struct packed {
        seqState_t           state;
        isaPkg::instrClass_t cls;
    } seqStep_t;

    typedef struct packed {
        logic      pcWrite;
        logic      pcWriteCond;
        logic      irWrite;
        logic      regWrite;
        logic      loadA;
        logic      loadB;
        logic      aluSrcA;     // 1 selects A, 0 selects PC
        logic      loadAluOut;
        logic      multDiv;
        logic      loadHi;
        logic      loadLo;
        logic      loadDiv;
        regDst_t   regDst;
        aluSrcB_t  aluSrcB;
        condCtrl_t condCtrl;
        aluOp_t    aluOp;
        pcSource_t pcSource;
        memToReg_t memToReg;
    } ctrlWord_t;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::opcode_t     opCode,
    input  isaPkg::funct_t      funct,
    output isaPkg::instrClass_t instrClass
);

    isaPkg::instrClass_t nextClass;

    always_comb begin
        nextClass = isaPkg::clsUnknown;
        case (opCode)
            isaPkg::OP_RTYPE: begin
                // R-type needs the function field
                case (funct)
                    isaPkg::FN_ADD:  nextClass = isaPkg::clsAdd;
                    isaPkg::FN_SUB:  nextClass = isaPkg::clsSub;
                    isaPkg::FN_AND:  nextClass = isaPkg::clsAnd;
                    isaPkg::FN_MULT: nextClass = isaPkg::clsMult;
                    isaPkg::FN_DIV:  nextClass = isaPkg::clsDiv;
                    isaPkg::FN_MFHI: nextClass = isaPkg::clsMfhi;
                    isaPkg::FN_MFLO: nextClass = isaPkg::clsMflo;
                    default:         nextClass = isaPkg::clsUnknown;
                endcase
            end
            isaPkg::OP_ADDI:  nextClass = isaPkg::clsAddi;
            isaPkg::OP_BNE:   nextClass = isaPkg::clsBne;
            isaPkg::OP_BEQ:   nextClass = isaPkg::clsBeq;
            isaPkg::OP_BLE:   nextClass = isaPkg::clsBle;
            isaPkg::OP_BGT:   nextClass = isaPkg::clsBgt;
            isaPkg::OP_RESET: nextClass = isaPkg::clsReset;
            default:          nextClass = isaPkg::clsUnknown;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instrClass <= isaPkg::clsUnknown;
        end else begin
            instrClass <= nextClass;  // One cycle behind the IR
        end
    end

endmodule

//--- stepSequencer.sv
`timescale 1ns/1ns

module stepSequencer #(
    parameter int MULDIV_STEPS = 33
) (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrClass_t instrClass,
    output ctrlPkg::seqStep_t   step
);

    localparam int FETCH_WAIT_STEPS = 3;
    localparam int CNT_MAX = (MULDIV_STEPS > FETCH_WAIT_STEPS) ? MULDIV_STEPS : FETCH_WAIT_STEPS;
    localparam int CNT_W = $clog2(CNT_MAX + 1);

    typedef logic [CNT_W-1:0] stepCount_t;

    localparam stepCount_t LAST_WAIT = stepCount_t'(FETCH_WAIT_STEPS - 1);
    localparam stepCount_t LAST_RUN  = stepCount_t'(MULDIV_STEPS - 1);

    stepCount_t          count;
    stepCount_t          nextCount;
    ctrlPkg::seqState_t  nextState;

    always_comb begin
        nextState = step.state;
        nextCount = '0;
        case (step.state)
            ctrlPkg::stReset:      nextState = ctrlPkg::stFetchWait;
            ctrlPkg::stFetchWait: begin
                if (count == LAST_WAIT) begin
                    nextState = ctrlPkg::stFetchLoad;
                end else begin
                    nextCount = count + 1'b1;
                end
            end
            ctrlPkg::stFetchLoad:  nextState = ctrlPkg::stDecode;
            ctrlPkg::stDecode:     nextState = ctrlPkg::stDispatch;
            ctrlPkg::stDispatch: begin
                case (instrClass)
                    isaPkg::clsAdd, isaPkg::clsSub,
                    isaPkg::clsAnd, isaPkg::clsAddi: nextState = ctrlPkg::stAluCompute;
                    isaPkg::clsMult, isaPkg::clsDiv: nextState = ctrlPkg::stMulDivRun;
                    isaPkg::clsMfhi, isaPkg::clsMflo: nextState = ctrlPkg::stMoveSelect;
                    isaPkg::clsBne, isaPkg::clsBeq,
                    isaPkg::clsBle, isaPkg::clsBgt:  nextState = ctrlPkg::stBranch;
                    isaPkg::clsReset:                nextState = ctrlPkg::stHalt;
                    default:                         nextState = ctrlPkg::stFetchWait;
                endcase
            end
            ctrlPkg::stAluCompute: nextState = ctrlPkg::stAluWrite;
            ctrlPkg::stMulDivRun: begin
                if (count == LAST_RUN) begin
                    nextState = ctrlPkg::stHiLoWrite;
                end else begin
                    nextCount = count + 1'b1;
                end
            end
            ctrlPkg::stMoveSelect: nextState = ctrlPkg::stMoveWrite;
            ctrlPkg::stHalt:       nextState = ctrlPkg::stHalt;  // Only reset leaves
            default:               nextState = ctrlPkg::stFetchWait;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step.state <= ctrlPkg::stReset;
            step.cls   <= isaPkg::clsUnknown;
            count      <= '0;
        end else begin
            step.state <= nextState;
            count      <= nextCount;
            if (step.state == ctrlPkg::stDispatch) begin
                step.cls <= instrClass;  // Held until next dispatch
            end
        end
    end

endmodule

//--- controlEncoder.sv
`timescale 1ns/1ns

module controlEncoder (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::seqStep_t  step,
    output ctrlPkg::ctrlWord_t ctrl,
    output logic               cpuReset
);

    ctrlPkg::ctrlWord_t nextCtrl;
    logic               nextCpuReset;
    logic               isRType;
    logic               isMult;

    function automatic ctrlPkg::aluOp_t aluOpFor(isaPkg::instrClass_t cls);
        case (cls)
            isaPkg::clsSub: return ctrlPkg::ALU_SUB;
            isaPkg::clsAnd: return ctrlPkg::ALU_AND;
            default:        return ctrlPkg::ALU_ADD;
        endcase
    endfunction

    function automatic ctrlPkg::condCtrl_t condFor(isaPkg::instrClass_t cls);
        case (cls)
            isaPkg::clsBeq: return ctrlPkg::COND_EQ;
            isaPkg::clsBle: return ctrlPkg::COND_LE;
            isaPkg::clsBgt: return ctrlPkg::COND_GT;
            default:        return ctrlPkg::COND_NE;
        endcase
    endfunction

    assign isRType = (step.cls != isaPkg::clsAddi);
    assign isMult  = (step.cls == isaPkg::clsMult);

    always_comb begin
        nextCtrl     = '0;
        nextCpuReset = 1'b0;
        case (step.state)
            ctrlPkg::stFetchWait, ctrlPkg::stFetchLoad: begin
                nextCtrl.aluSrcB  = ctrlPkg::SRCB_FOUR;  // PC + 4
                nextCtrl.aluOp    = ctrlPkg::ALU_ADD;
                nextCtrl.pcSource = ctrlPkg::PC_SRC_ALU;
                if (step.state == ctrlPkg::stFetchLoad) begin
                    nextCtrl.pcWrite = 1'b1;
                    nextCtrl.irWrite = 1'b1;
                end
            end
            ctrlPkg::stDecode: begin
                // Registers read while ALUOut takes the branch target
                nextCtrl.loadA      = 1'b1;
                nextCtrl.loadB      = 1'b1;
                nextCtrl.loadAluOut = 1'b1;
                nextCtrl.aluSrcB    = ctrlPkg::SRCB_IMM_SHIFT;
                nextCtrl.aluOp      = ctrlPkg::ALU_ADD;
            end
            ctrlPkg::stAluCompute, ctrlPkg::stAluWrite: begin
                nextCtrl.aluSrcA    = 1'b1;
                nextCtrl.loadAluOut = 1'b1;
                nextCtrl.aluOp      = aluOpFor(step.cls);
                nextCtrl.memToReg   = ctrlPkg::MEM_TO_REG_ALUOUT;
                nextCtrl.regWrite   = (step.state == ctrlPkg::stAluWrite);
                if (isRType) begin
                    nextCtrl.aluSrcB = ctrlPkg::SRCB_B;
                    nextCtrl.regDst  = ctrlPkg::REG_DST_RD;
                end else begin
                    nextCtrl.aluSrcB = ctrlPkg::SRCB_IMM;
                    nextCtrl.regDst  = ctrlPkg::REG_DST_RT;
                end
            end
            ctrlPkg::stMulDivRun: begin
                nextCtrl.multDiv = isMult;
                nextCtrl.loadDiv = !isMult;
            end
            ctrlPkg::stHiLoWrite: begin
                nextCtrl.loadHi  = 1'b1;
                nextCtrl.loadLo  = 1'b1;
                nextCtrl.multDiv = isMult;  // Multiplier result still selected
            end
            ctrlPkg::stMoveSelect, ctrlPkg::stMoveWrite: begin
                nextCtrl.regDst   = ctrlPkg::REG_DST_RD;
                nextCtrl.memToReg = (step.cls == isaPkg::clsMfhi) ? ctrlPkg::MEM_TO_REG_HI
                                                                  : ctrlPkg::MEM_TO_REG_LO;
                nextCtrl.regWrite = (step.state == ctrlPkg::stMoveWrite);
            end
            ctrlPkg::stBranch: begin
                nextCtrl.pcWriteCond = 1'b1;
                nextCtrl.aluSrcA     = 1'b1;
                nextCtrl.aluOp       = ctrlPkg::ALU_CMP;
                nextCtrl.pcSource    = ctrlPkg::PC_SRC_BRANCH;
                nextCtrl.condCtrl    = condFor(step.cls);
            end
            ctrlPkg::stReset, ctrlPkg::stHalt: nextCpuReset = 1'b1;
            default: nextCtrl = '0;  // Dispatch word
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl     <= '0;
            cpuReset <= 1'b1;
        end else begin
            ctrl     <= nextCtrl;
            cpuReset <= nextCpuReset;
        end
    end

endmodule

//--- controlUnit.sv
`timescale 1ns/1ns

module controlUnit #(
    parameter int MULDIV_STEPS = 33
) (
    input  logic               clk,
    input  logic               reset,
    input  isaPkg::opcode_t    opCode,
    input  isaPkg::funct_t     funct,
    output ctrlPkg::ctrlWord_t ctrl,
    output logic               cpuReset
);

    isaPkg::instrClass_t instrClass;
    ctrlPkg::seqStep_t   step;

    instrDecoder decoder0 (
        .clk        (clk),
        .reset      (reset),
        .opCode     (opCode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    // Fetch, dispatch and multicycle execute steps
    stepSequencer #(
        .MULDIV_STEPS (MULDIV_STEPS)
    ) sequencer0 (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .step       (step)
    );

    controlEncoder encoder0 (
        .clk      (clk),
        .reset    (reset),
        .step     (step),
        .ctrl     (ctrl),
        .cpuReset (cpuReset)
    );

endmodule

//--- controlUnit_checker.sv
`timescale 1ns/1ns

module controlUnit_checker (
    input logic               clk,
    input logic               reset,
    input ctrlPkg::ctrlWord_t ctrl,
    input logic               cpuReset
);

    int failCount = 0;

    pcWriteExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pcWrite && ctrl.pcWriteCond))
        else begin
            $error("pcWrite and pcWriteCond high together");
            failCount++;
        end

    // Hi and Lo always load as a pair
    hiLoPaired: assert property (@(posedge clk) disable iff (reset)
        ctrl.loadHi == ctrl.loadLo)
        else begin
            $error("loadHi differs from loadLo");
            failCount++;
        end

    regIrExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.regWrite && ctrl.irWrite))
        else begin
            $error("regWrite and irWrite high together");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) disable iff (reset)
        cpuReset |-> (ctrl == '0))
        else begin
            $error("ctrl not zero while cpuReset is high");
            failCount++;
        end

endmodule

bind controlUnit controlUnit_checker checker0 (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .cpuReset (cpuReset)
);

//--- controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb;

    localparam int MULDIV_STEPS = 9;
    localparam int FETCH_TIMEOUT = 8;
    localparam int HALT_CYCLES = 50;
    localparam logic [31:0] LCG_SEED = 32'he8c485fe;

    typedef struct packed {
        isaPkg::opcode_t     op;
        isaPkg::funct_t      fn;
        isaPkg::instrClass_t cls;
    } testInstr_t;

    // Entries 12 to 15 are unsupported encodings and RESET sits last
    localparam testInstr_t INSTR_TABLE [17] = '{
        '{isaPkg::OP_RTYPE, isaPkg::FN_ADD, isaPkg::clsAdd},
        '{isaPkg::OP_RTYPE, isaPkg::FN_SUB, isaPkg::clsSub},
        '{isaPkg::OP_RTYPE, isaPkg::FN_AND, isaPkg::clsAnd},
        '{isaPkg::OP_ADDI, 6'h00, isaPkg::clsAddi},
        '{isaPkg::OP_RTYPE, isaPkg::FN_MULT, isaPkg::clsMult},
        '{isaPkg::OP_RTYPE, isaPkg::FN_DIV, isaPkg::clsDiv},
        '{isaPkg::OP_RTYPE, isaPkg::FN_MFHI, isaPkg::clsMfhi},
        '{isaPkg::OP_RTYPE, isaPkg::FN_MFLO, isaPkg::clsMflo},
        '{isaPkg::OP_BNE, 6'h00, isaPkg::clsBne},
        '{isaPkg::OP_BEQ, 6'h00, isaPkg::clsBeq},
        '{isaPkg::OP_BLE, 6'h00, isaPkg::clsBle},
        '{isaPkg::OP_BGT, 6'h00, isaPkg::clsBgt},
        '{6'h02, 6'h00, isaPkg::clsUnknown},            // Jump
        '{isaPkg::OP_RTYPE, 6'h00, isaPkg::clsUnknown}, // Shift
        '{6'h23, 6'h00, isaPkg::clsUnknown},            // Load word
        '{isaPkg::OP_RTYPE, 6'h2a, isaPkg::clsUnknown},
        '{isaPkg::OP_RESET, 6'h00, isaPkg::clsReset}
    };

    logic               clk = 1'b0;
    logic               reset;
    isaPkg::opcode_t    opCode;
    isaPkg::funct_t     funct;
    ctrlPkg::ctrlWord_t ctrl;
    logic               cpuReset;

    int          errors = 0;
    int          checks = 0;
    int          checkerFails = 0;
    logic        timedOut = 1'b0;
    logic [31:0] lcgState = LCG_SEED;

    controlUnit #(
        .MULDIV_STEPS (MULDIV_STEPS)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .opCode   (opCode),
        .funct    (funct),
        .ctrl     (ctrl),
        .cpuReset (cpuReset)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic ctrlPkg::ctrlWord_t fetchWord(logic load);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.aluSrcB = ctrlPkg::SRCB_FOUR;
        w.aluOp   = ctrlPkg::ALU_ADD;
        w.pcWrite = load;
        w.irWrite = load;
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t decodeWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.loadA      = 1'b1;
        w.loadB      = 1'b1;
        w.loadAluOut = 1'b1;
        w.aluSrcB    = ctrlPkg::SRCB_IMM_SHIFT;
        w.aluOp      = ctrlPkg::ALU_ADD;
        return w;
    endfunction

    function automatic int execLength(isaPkg::instrClass_t cls);
        case (cls)
            isaPkg::clsMult, isaPkg::clsDiv: return MULDIV_STEPS + 1;
            isaPkg::clsBne, isaPkg::clsBeq, isaPkg::clsBle, isaPkg::clsBgt: return 1;
            isaPkg::clsUnknown, isaPkg::clsReset: return 0;
            default: return 2;  // ALU ops and moves
        endcase
    endfunction

    // Expected word at execute position idx
    function automatic ctrlPkg::ctrlWord_t execWord(isaPkg::instrClass_t cls, int idx);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        case (cls)
            isaPkg::clsAdd, isaPkg::clsSub, isaPkg::clsAnd, isaPkg::clsAddi: begin
                w.aluSrcA    = 1'b1;
                w.loadAluOut = 1'b1;
                w.regWrite   = (idx == 1);
                w.aluOp      = (cls == isaPkg::clsSub) ? ctrlPkg::ALU_SUB :
                               (cls == isaPkg::clsAnd) ? ctrlPkg::ALU_AND : ctrlPkg::ALU_ADD;
                w.aluSrcB    = (cls == isaPkg::clsAddi) ? ctrlPkg::SRCB_IMM : ctrlPkg::SRCB_B;
                w.regDst     = (cls == isaPkg::clsAddi) ? ctrlPkg::REG_DST_RT : ctrlPkg::REG_DST_RD;
            end
            isaPkg::clsMult, isaPkg::clsDiv: begin
                w.multDiv = (cls == isaPkg::clsMult);
                w.loadDiv = (cls == isaPkg::clsDiv) && (idx < MULDIV_STEPS);
                w.loadHi  = (idx == MULDIV_STEPS);
                w.loadLo  = (idx == MULDIV_STEPS);
            end
            isaPkg::clsMfhi, isaPkg::clsMflo: begin
                w.regDst   = ctrlPkg::REG_DST_RD;
                w.memToReg = (cls == isaPkg::clsMfhi) ? ctrlPkg::MEM_TO_REG_HI
                                                      : ctrlPkg::MEM_TO_REG_LO;
                w.regWrite = (idx == 1);
            end
            isaPkg::clsBne, isaPkg::clsBeq, isaPkg::clsBle, isaPkg::clsBgt: begin
                w.pcWriteCond = 1'b1;
                w.aluSrcA     = 1'b1;
                w.aluOp       = ctrlPkg::ALU_CMP;
                w.pcSource    = ctrlPkg::PC_SRC_BRANCH;
                w.condCtrl    = (cls == isaPkg::clsBeq) ? ctrlPkg::COND_EQ :
                                (cls == isaPkg::clsBle) ? ctrlPkg::COND_LE :
                                (cls == isaPkg::clsBgt) ? ctrlPkg::COND_GT : ctrlPkg::COND_NE;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkOutputs(input ctrlPkg::ctrlWord_t expCtrl, input logic expCpuReset);
        checks++;
        assert (ctrl === expCtrl) else begin
            errors++;
            $display("** Error at %0t: ctrl = %h, expected %h", $time, ctrl, expCtrl);
        end
        assert (cpuReset === expCpuReset) else begin
            errors++;
            $display("** Error at %0t: cpuReset = %b, expected %b", $time, cpuReset, expCpuReset);
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (4) begin
            nextCycle();
            checkOutputs('0, 1'b1);
        end
        reset = 1'b0;
        nextCycle();
        checkOutputs('0, 1'b1);  // Sequencer still leaving stReset
    endtask

    // Counts fetch wait words until the IR load word
    task automatic waitIrWrite(output int nWait);
        nWait = 0;
        nextCycle();
        while (!ctrl.irWrite && nWait < FETCH_TIMEOUT) begin
            checkOutputs(fetchWord(1'b0), 1'b0);
            nWait++;
            nextCycle();
        end
        if (!ctrl.irWrite) begin
            errors++;
            timedOut = 1'b1;
            $display("Timeout: irWrite not seen within %0d cycles at %0t", FETCH_TIMEOUT, $time);
        end
    endtask

    task automatic runInstr(input testInstr_t ins);
        int nWait;
        if (timedOut) return;
        waitIrWrite(nWait);
        if (timedOut) return;
        checkOutputs(fetchWord(1'b1), 1'b0);
        assert (nWait == 3) else begin
            errors++;
            $display("** Error at %0t: fetch wait words = %0d, expected 3", $time, nWait);
        end
        opCode = ins.op;  // Held until the next IR load
        funct  = ins.fn;
        nextCycle();
        checkOutputs(decodeWord(), 1'b0);
        nextCycle();
        checkOutputs('0, 1'b0);  // Dispatch
        if (ins.cls == isaPkg::clsReset) begin
            repeat (HALT_CYCLES) begin
                nextCycle();
                checkOutputs('0, 1'b1);
            end
        end else begin
            for (int i = 0; i < execLength(ins.cls); i++) begin
                nextCycle();
                checkOutputs(execWord(ins.cls, i), 1'b0);
            end
        end
    endtask

    task automatic resetThenFetch();
        applyReset();
        runInstr(INSTR_TABLE[12]);  // Unknown class gives only the fetch words
    endtask

    task automatic aluOps();
        for (int i = 0; i < 4; i++) begin
            runInstr(INSTR_TABLE[i]);
        end
    endtask

    task automatic mulDivOps();
        runInstr(INSTR_TABLE[4]);
        runInstr(INSTR_TABLE[5]);
    endtask

    task automatic movesAndBranches();
        for (int i = 6; i < 12; i++) begin
            runInstr(INSTR_TABLE[i]);
        end
    endtask

    task automatic randomStream();
        logic [31:0] r;
        testInstr_t  ins;
        for (int n = 0; n < 20; n++) begin
            r = lcgNext();
            ins = INSTR_TABLE[r[19:16]];  // Never the RESET entry
            if (ins.op != isaPkg::OP_RTYPE) begin
                ins.fn = r[5:0];  // Funct ignored outside R-type
            end
            runInstr(ins);
        end
    endtask

    task automatic haltAndRestart();
        runInstr(INSTR_TABLE[16]);
        applyReset();
        runInstr(INSTR_TABLE[0]);
    endtask

    initial begin
        reset  = 1'b1;
        opCode = '0;
        funct  = '0;
        resetThenFetch();
        aluOps();
        mulDivOps();
        movesAndBranches();
        randomStream();
        haltAndRestart();
        checkerFails = dut0.checker0.failCount;
        $display("Words checked: %0d, errors: %0d, checker failures: %0d",
                 checks, errors, checkerFails);
        if (errors == 0 && checkerFails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlEncoder.sv
controlUnit.sv
controlUnit_checker.sv
controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
